//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_resp_distributor
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
source/resp_pkg.sv
source/resp_fifo_if.sv
source/resp_ingress.sv
source/resp_fifo.sv
source/resp_dispatch_ctrl.sv
source/resp_fanout.sv
source/resp_distributor_top.sv
tb/resp_distributor_props.sv
tb/tb_resp_distributor.sv

//--- source/resp_dispatch_ctrl.sv
`timescale 1ns/100ps

module resp_dispatch_ctrl (
  input  logic                 ap_clk,
  input  logic                 areset_control,
  input  resp_pkg::dest_mask_t req_ready,
  resp_fifo_if.pop             fifo,
  output logic                 issue
);
  import resp_pkg::*;

  dest_mask_t      ready_reg;
  dispatch_state_e state;
  dispatch_state_e state_next;
  logic            head_covered;

  // --------------------------------------
  // Registered ready levels
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_reg <= '0;
    end else begin
      ready_reg <= req_ready;
    end
  end

  // Every lane the head addresses was ready last cycle
  assign head_covered = ((fifo.dout.dest & ~ready_reg) == '0);

  // --------------------------------------
  // Dispatch FSM
  // --------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= DISPATCH_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      DISPATCH_IDLE: begin
        if (!fifo.empty) begin
          state_next = DISPATCH_WAIT;
        end
      end
      DISPATCH_WAIT: begin
        // Head of line blocks everything behind it
        if (head_covered) begin
          state_next = DISPATCH_ISSUE;
        end
      end
      DISPATCH_ISSUE: begin
        state_next = DISPATCH_IDLE;
      end
      default: begin
        state_next = DISPATCH_IDLE;
      end
    endcase
  end

  // Single cycle pop, fanout samples the head on the same edge
  assign issue      = (state == DISPATCH_ISSUE);
  assign fifo.rd_en = (state == DISPATCH_ISSUE);

endmodule : resp_dispatch_ctrl

//--- source/resp_distributor_top.sv
`timescale 1ns/100ps

module resp_distributor_top (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  // Memory side, four-phase
  input  logic                            mem_req,
  output logic                            mem_ack,
  input  resp_pkg::dest_mask_t            mem_dest,
  input  resp_pkg::resp_opcode_e          mem_opcode,
  input  logic [resp_pkg::TAG_WIDTH-1:0]  mem_tag,
  input  logic [resp_pkg::DATA_WIDTH-1:0] mem_data,
  // Requestor side
  input  resp_pkg::dest_mask_t            req_ready,
  output resp_pkg::dest_mask_t            resp_valid,
  output resp_pkg::resp_opcode_e         resp_opcode,
  output logic [resp_pkg::TAG_WIDTH-1:0]  resp_tag,
  output logic [resp_pkg::DATA_WIDTH-1:0] resp_data
);
  import resp_pkg::*;

  response_packet_t mem_packet;
  logic             issue;

  resp_fifo_if fifo_bus ();

  assign mem_packet.dest   = mem_dest;
  assign mem_packet.opcode = mem_opcode;
  assign mem_packet.tag    = mem_tag;
  assign mem_packet.data   = mem_data;

  // --------------------------------------
  // Ingress and buffer
  // --------------------------------------
  resp_ingress u_ingress (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .mem_req        (mem_req),
    .mem_ack        (mem_ack),
    .mem_packet     (mem_packet),
    .fifo           (fifo_bus.push)
  );

  resp_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .fifo           (fifo_bus.store)
  );

  // --------------------------------------
  // Release and fanout
  // --------------------------------------
  resp_dispatch_ctrl u_dispatch (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .req_ready      (req_ready),
    .fifo           (fifo_bus.pop),
    .issue          (issue)
  );

  resp_fanout u_fanout (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .issue          (issue),
    .fifo           (fifo_bus.pop),
    .resp_valid     (resp_valid),
    .resp_opcode    (resp_opcode),
    .resp_tag       (resp_tag),
    .resp_data      (resp_data)
  );

endmodule : resp_distributor_top

//--- source/resp_fanout.sv
`timescale 1ns/100ps

module resp_fanout (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  logic                            issue,
  resp_fifo_if.pop                        fifo,
  output resp_pkg::dest_mask_t            resp_valid,
  output resp_pkg::resp_opcode_e          resp_opcode,
  output logic [resp_pkg::TAG_WIDTH-1:0]  resp_tag,
  output logic [resp_pkg::DATA_WIDTH-1:0] resp_data
);
  import resp_pkg::*;

  // --------------------------------------
  // Per-lane valid
  // --------------------------------------
  // Mask expands to lanes, all addressed lanes fire together
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_valid <= '0;
    end else begin
      for (int lane = 0; lane < NUM_REQUESTORS; lane++) begin
        resp_valid[lane] <= issue & fifo.dout.dest[lane];
      end
    end
  end

  // Shared payload, registered once for every lane
  always_ff @(posedge ap_clk) begin
    if (issue) begin
      resp_opcode <= fifo.dout.opcode;
      resp_tag    <= fifo.dout.tag;
      resp_data   <= fifo.dout.data;
    end
  end

endmodule : resp_fanout

//--- source/resp_fifo.sv
`timescale 1ns/100ps

module resp_fifo #(
  parameter int DEPTH = 8
) (
  input  logic       ap_clk,
  input  logic       areset_control,
  resp_fifo_if.store fifo
);
  import resp_pkg::*;

  // --------------------------------------
  // Storage and pointers
  // --------------------------------------
  response_packet_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;

  logic do_write;
  logic do_read;

  // Ignore a write when full and a read when empty
  assign do_write = fifo.wr_en && !fifo.full;
  assign do_read  = fifo.rd_en && !fifo.empty;

  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= fifo.din;
    end
  end

  // Pointers wrap by themselves for power-of-two depths
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------
  // Flags and first-word-fall-through head
  // --------------------------------------
  assign fifo.full  = (count == DEPTH);
  assign fifo.empty = (count == '0);

  // Head is visible the cycle after it is written
  assign fifo.dout = mem[rd_ptr];

endmodule : resp_fifo

//--- source/resp_fifo_if.sv
`timescale 1ns/100ps

interface resp_fifo_if;
  import resp_pkg::*;

  // Push side
  logic             wr_en;
  response_packet_t din;
  logic             full;

  // Pop side, head shows on dout while not empty
  logic             rd_en;
  response_packet_t dout;
  logic             empty;

  modport push (
    output wr_en, din,
    input  full
  );

  modport store (
    input  wr_en, din, rd_en,
    output full, dout, empty
  );

  // Fanout only watches dout through this one
  modport pop (
    output rd_en,
    input  empty, dout
  );

endinterface : resp_fifo_if

//--- source/resp_ingress.sv
`timescale 1ns/100ps

module resp_ingress (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       mem_req,
  output logic                       mem_ack,
  input  resp_pkg::response_packet_t mem_packet,
  resp_fifo_if.push                  fifo
);
  import resp_pkg::*;

  typedef enum logic {
    INGRESS_IDLE,
    INGRESS_HOLD
  } ingress_state_e;

  ingress_state_e   state;
  response_packet_t packet_reg;
  logic             wr_pulse;
  logic             accept;

  // --------------------------------------
  // Four-phase receiver
  // --------------------------------------
  // Take a new response only with ack low and room in the FIFO
  assign accept = (state == INGRESS_IDLE) && mem_req && !fifo.full;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state    <= INGRESS_IDLE;
      wr_pulse <= 1'b0;
    end else begin
      // Empty masks are acked but never stored
      wr_pulse <= accept && (|mem_packet.dest);
      case (state)
        INGRESS_IDLE: begin
          if (accept) begin
            state <= INGRESS_HOLD;
          end
        end
        INGRESS_HOLD: begin
          // Release ack once the source has dropped req
          if (!mem_req) begin
            state <= INGRESS_IDLE;
          end
        end
        default: state <= INGRESS_IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept) begin
      packet_reg <= mem_packet;
    end
  end

  assign mem_ack    = (state == INGRESS_HOLD);
  assign fifo.wr_en = wr_pulse;
  assign fifo.din   = packet_reg;

endmodule : resp_ingress

//--- source/resp_pkg.sv
package resp_pkg;

  // --------------------------------------
  // Sizing
  // --------------------------------------
  localparam int NUM_REQUESTORS = 4;
  localparam int DATA_WIDTH     = 32;
  localparam int TAG_WIDTH      = 6;
  localparam int FIFO_DEPTH     = 8;

  // One bit per requestor lane
  typedef logic [NUM_REQUESTORS-1:0] dest_mask_t;

  // Carried through untouched from memory to requestor
  typedef enum logic [2:0] {
    READ_DATA   = 3'd0,
    WRITE_ACK   = 3'd1,
    ATOMIC_DATA = 3'd2
  } resp_opcode_e;

  // --------------------------------------
  // Response packet, 45 bits
  // --------------------------------------
  typedef struct packed {
    dest_mask_t             dest;
    resp_opcode_e           opcode;
    logic [TAG_WIDTH-1:0]   tag;
    logic [DATA_WIDTH-1:0]  data;
  } response_packet_t;

  // Dispatch FSM states
  typedef enum logic [1:0] {
    DISPATCH_IDLE  = 2'd0,
    DISPATCH_WAIT  = 2'd1,
    DISPATCH_ISSUE = 2'd2
  } dispatch_state_e;

endpackage : resp_pkg

//--- tb/resp_distributor_props.sv
`timescale 1ns/100ps

module resp_distributor_props (
  input logic                 ap_clk,
  input logic                 areset_control,
  input logic                 mem_req,
  input logic                 mem_ack,
  input resp_pkg::dest_mask_t resp_valid,
  input logic                 rd_en,
  input logic                 empty
);

  // --------------------------------------
  // Memory side four-phase rules
  // --------------------------------------
  ack_rise_needs_req: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    $rose(mem_ack) |-> $past(mem_req)
  ) else $error("mem_ack rose while mem_req was low");

  // Ack only drops once the source has withdrawn req
  ack_fall_needs_no_req: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    $fell(mem_ack) |-> !$past(mem_req)
  ) else $error("mem_ack fell while mem_req was still high");

  // --------------------------------------
  // Output and FIFO rules
  // --------------------------------------
  valid_clear_in_reset: assert property (
    @(posedge ap_clk) areset_control |=> (resp_valid == '0)
  ) else $error("resp_valid not cleared by reset");

  no_pop_when_empty: assert property (
    @(posedge ap_clk) disable iff (areset_control)
    rd_en |-> !empty
  ) else $error("FIFO read while empty");

endmodule : resp_distributor_props

bind resp_distributor_top resp_distributor_props u_props (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .mem_req        (mem_req),
  .mem_ack        (mem_ack),
  .resp_valid     (resp_valid),
  .rd_en          (fifo_bus.rd_en),
  .empty          (fifo_bus.empty)
);

//--- tb/tb_resp_distributor.sv
`timescale 1ns/100ps

module tb_resp_distributor;
  import resp_pkg::*;

  localparam int ACK_TIMEOUT   = 100;
  localparam int DRAIN_TIMEOUT = 500;

  logic                  ap_clk;
  logic                  areset_control;
  logic                  mem_req;
  logic                  mem_ack;
  response_packet_t      mem_pkt;
  dest_mask_t            req_ready;
  dest_mask_t            resp_valid;
  resp_opcode_e          resp_opcode;
  logic [TAG_WIDTH-1:0]  resp_tag;
  logic [DATA_WIDTH-1:0] resp_data;

  integer seed = 32'h1929_ee76;
  int     value_errors = 0;
  int     timeout_errors = 0;
  int     other_errors = 0;

  // Expected traffic per lane, in acceptance order
  response_packet_t lane_q [NUM_REQUESTORS][$];
  // Stage 0 mirrors the registered ready, two more line it up with resp_valid
  dest_mask_t       ready_pipe [3];

  resp_distributor_top DUT (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .mem_req        (mem_req),
    .mem_ack        (mem_ack),
    .mem_dest       (mem_pkt.dest),
    .mem_opcode     (mem_pkt.opcode),
    .mem_tag        (mem_pkt.tag),
    .mem_data       (mem_pkt.data),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .resp_opcode    (resp_opcode),
    .resp_tag       (resp_tag),
    .resp_data      (resp_data)
  );

  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;

  // Every addressed lane gets the response, a zero mask reaches nobody
  function automatic dest_mask_t expected_lanes(input response_packet_t pkt);
    return pkt.dest;
  endfunction

  function automatic int pending_count();
    int total;
    total = 0;
    for (int lane = 0; lane < NUM_REQUESTORS; lane++) begin
      total += lane_q[lane].size();
    end
    return total;
  endfunction

  // --------------------------------------
  // Compare tasks
  // --------------------------------------
  task automatic check_packet(input string name, input response_packet_t exp,
                              input response_packet_t act);
    if (act !== exp) begin
      value_errors++;
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_lanes(input string name, input dest_mask_t exp, input dest_mask_t act);
    if (act !== exp) begin
      value_errors++;
      $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
    end
  endtask

  // --------------------------------------
  // Driver
  // --------------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  task automatic wait_for_ack(input logic level);
    int cycles;
    cycles = 0;
    while (mem_ack !== level && cycles < ACK_TIMEOUT) begin
      idle_cycles(1);
      cycles++;
    end
    if (mem_ack !== level) begin
      timeout_errors++;
      $display("Timeout at %0t: mem_ack never went to %0b", $time, level);
    end
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (pending_count() != 0 && cycles < DRAIN_TIMEOUT) begin
      idle_cycles(1);
      cycles++;
    end
    if (pending_count() != 0) begin
      timeout_errors++;
      $display("Timeout at %0t: %0d expected responses never arrived", $time, pending_count());
    end
  endtask

  task automatic record_expected(input response_packet_t pkt);
    dest_mask_t lanes;
    lanes = expected_lanes(pkt);
    for (int lane = 0; lane < NUM_REQUESTORS; lane++) begin
      if (lanes[lane]) begin
        lane_q[lane].push_back(pkt);
      end
    end
  endtask

  // Full four-phase transfer of one response
  task automatic send_response(input response_packet_t pkt);
    mem_pkt = pkt;
    mem_req = 1'b1;
    wait_for_ack(1'b1);
    record_expected(pkt);
    mem_req = 1'b0;
    wait_for_ack(1'b0);
  endtask

  task automatic make_packet(input dest_mask_t dest, output response_packet_t pkt);
    logic [31:0] rnd;
    rnd = $random(seed);
    pkt.dest = dest;
    case (rnd[1:0])
      2'd0:    pkt.opcode = READ_DATA;
      2'd1:    pkt.opcode = WRITE_ACK;
      default: pkt.opcode = ATOMIC_DATA;
    endcase
    pkt.tag  = rnd[TAG_WIDTH+1:2];
    pkt.data = $random(seed);
  endtask

  // --------------------------------------
  // Ready history and compare process
  // --------------------------------------
  always @(posedge ap_clk) begin
    if (areset_control) begin
      ready_pipe[0] <= '0;
      ready_pipe[1] <= '0;
      ready_pipe[2] <= '0;
    end else begin
      ready_pipe[0] <= req_ready;
      ready_pipe[1] <= ready_pipe[0];
      ready_pipe[2] <= ready_pipe[1];
    end
  end

  always @(negedge ap_clk) begin : compare_outputs
    response_packet_t act_pkt;
    if (!areset_control && resp_valid != '0) begin
      // A lane may only fire if it was ready when release was decided
      check_lanes("resp_valid on unready lane", '0, resp_valid & ~ready_pipe[2]);
      act_pkt = {resp_valid, resp_opcode, resp_tag, resp_data};
      for (int lane = 0; lane < NUM_REQUESTORS; lane++) begin
        if (resp_valid[lane] && lane_q[lane].size() == 0) begin
          other_errors++;
          $display("Unexpected response on lane %0d at %0t", lane, $time);
        end else if (resp_valid[lane]) begin
          check_packet($sformatf("resp lane %0d", lane), lane_q[lane].pop_front(), act_pkt);
        end
      end
    end
  end

  initial begin : stimulus
    response_packet_t pkt;
    logic [31:0]      rnd;
    dest_mask_t       mask;
    areset_control = 1'b1;
    mem_req        = 1'b0;
    mem_pkt        = '0;
    req_ready      = '0;

    // Reset held for four cycles
    repeat (4) begin
      @(posedge ap_clk);
      #1;
      check_bit("mem_ack", 1'b0, mem_ack);
      check_lanes("resp_valid", '0, resp_valid);
    end
    areset_control = 1'b0;

    // Still quiet right after reset
    repeat (3) begin
      @(posedge ap_clk);
      #1;
      check_bit("mem_ack", 1'b0, mem_ack);
      check_lanes("resp_valid", '0, resp_valid);
    end

    // Unicast, all lanes ready
    req_ready = '1;
    repeat (16) begin
      rnd  = $random(seed);
      mask = '0;
      mask[$unsigned(rnd) % NUM_REQUESTORS] = 1'b1;
      make_packet(mask, pkt);
      send_response(pkt);
    end
    wait_for_drain();

    // Multicast
    repeat (10) begin
      rnd  = $random(seed);
      mask = rnd[NUM_REQUESTORS-1:0];
      if ($countones(mask) < 2) begin
        mask = '1;
      end
      make_packet(mask, pkt);
      send_response(pkt);
    end
    wait_for_drain();

    // Zero masks are acked and dropped
    make_packet('0, pkt);
    send_response(pkt);
    make_packet(4'b0010, pkt);
    send_response(pkt);
    make_packet('0, pkt);
    send_response(pkt);
    wait_for_drain();
    idle_cycles(10);

    // Lane 2 not ready blocks the head and everything behind it
    req_ready    = '1;
    req_ready[2] = 1'b0;
    make_packet(4'b0101, pkt);
    send_response(pkt);
    make_packet(4'b0001, pkt);
    send_response(pkt);
    make_packet(4'b0010, pkt);
    send_response(pkt);
    idle_cycles(20);
    if (pending_count() != 4) begin
      other_errors++;
      $display("Responses went past a blocked head, %0d left instead of 4", pending_count());
    end
    req_ready = '1;
    wait_for_drain();

    // FIFO full holds off the next ack
    req_ready = '0;
    repeat (FIFO_DEPTH) begin
      rnd = $random(seed);
      make_packet(rnd[NUM_REQUESTORS-1:0] | 4'b1000, pkt);
      send_response(pkt);
    end
    make_packet(4'b0110, pkt);
    mem_pkt = pkt;
    mem_req = 1'b1;
    repeat (12) begin
      idle_cycles(1);
      check_bit("mem_ack", 1'b0, mem_ack);
    end
    req_ready = '1;
    wait_for_ack(1'b1);
    record_expected(pkt);
    mem_req = 1'b0;
    wait_for_ack(1'b0);
    wait_for_drain();
    idle_cycles(10);

    $display("Error counts: value=%0d timeout=%0d other=%0d",
             value_errors, timeout_errors, other_errors);
    if (value_errors + timeout_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_resp_distributor
